// ==== verilog/cam_pkg.sv ====
package cam_pkg;

    localparam int BYTE_W     = 8;    // camera byte
    localparam int PIX565_W   = 16;   // packed pixel
    localparam int PIX888_W   = 24;   // output pixel

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;    // log2 of FIFO_DEPTH

    localparam int APB_AW     = 4;
    localparam int APB_DW     = 16;

    localparam logic [APB_AW-1:0] ADDR_CMD    = 4'h0;   // command byte, write
    localparam logic [APB_AW-1:0] ADDR_STATUS = 4'h4;   // status word, read

    // upper nibble of a command byte
    localparam logic [3:0] CMD_BRIGHT_UP   = 4'd1;
    localparam logic [3:0] CMD_BRIGHT_DOWN = 4'd2;
    localparam logic [3:0] CMD_GRAY        = 4'd3;
    localparam logic [3:0] CMD_CLR_OVF     = 4'd4;

    localparam int BRIGHT_MAX = 127;  // +/- limit of the offset

    typedef logic signed [BYTE_W-1:0] bright_t;

    typedef struct packed {
        logic [3:0] ctrl;     // command code
        logic [3:0] value;    // command argument
    } cmd_fields_t;

    // one command byte, seen raw or split into code and value
    typedef union packed {
        logic [BYTE_W-1:0] raw;
        cmd_fields_t       fields;
    } cmd_byte_u;

endpackage

// ==== verilog/pix_if.sv ====
`timescale 1ns/1ps

interface pix_if;

    logic                         valid;
    logic                         ready;
    logic                         sof;    // first pixel of a frame
    logic [cam_pkg::PIX565_W-1:0] data;   // rgb565

    modport src (
        output valid,
        output sof,
        output data,
        input  ready
    );

    modport snk (
        input  valid,
        input  sof,
        input  data,
        output ready
    );

endinterface

// ==== verilog/cmos_pixel_pack.sv ====
`timescale 1ns/1ps

module cmos_pixel_pack (
    input  logic                       clk_50M,
    input  logic                       sys_rst,
    input  logic                       href_i,
    input  logic                       vsync_i,
    input  logic [cam_pkg::BYTE_W-1:0] data_i,
    pix_if.src                         pix
);

    logic                       href_d;     // sampled camera inputs
    logic                       vsync_d;
    logic [cam_pkg::BYTE_W-1:0] data_d;
    logic                       phase;      // high byte already held
    logic [cam_pkg::BYTE_W-1:0] hi_byte;
    logic                       sof_pend;   // vsync seen, no word yet
    logic                       word_done;

    assign word_done = href_d & phase;

    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            href_d  <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            href_d  <= href_i;
            vsync_d <= vsync_i;
        end
    end

    always_ff @(posedge clk_50M) begin
        data_d <= data_i;
        if (href_d && !phase) begin
            hi_byte <= data_d;
        end
        if (word_done) begin
            pix.data <= {hi_byte, data_d};   // r5 g6 b5
        end
    end

    // no stall here, a full FIFO simply drops the word
    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            phase     <= 1'b0;
            sof_pend  <= 1'b0;
            pix.valid <= 1'b0;
            pix.sof   <= 1'b0;
        end else begin
            phase     <= href_d & ~phase;   // restarts on every href low
            pix.valid <= word_done;
            if (word_done) begin
                pix.sof <= sof_pend;
            end
            if (vsync_d) begin
                sof_pend <= 1'b1;
            end else if (word_done) begin
                sof_pend <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/pixel_fifo.sv ====
`timescale 1ns/1ps

module pixel_fifo (
    input  logic clk_50M,
    input  logic sys_rst,
    pix_if.snk   wr,
    pix_if.src   rd,
    input  logic ovf_clr_i,
    output logic overflow_o
);

    logic [cam_pkg::PIX565_W:0]  mem [cam_pkg::FIFO_DEPTH];   // {sof, data}
    logic [cam_pkg::FIFO_AW-1:0] wr_ptr;
    logic [cam_pkg::FIFO_AW-1:0] rd_ptr;
    logic [cam_pkg::FIFO_AW:0]   count;
    logic                        push;
    logic                        pop;

    assign wr.ready = (count != cam_pkg::FIFO_DEPTH);
    assign rd.valid = (count != '0);
    assign push     = wr.valid & wr.ready;
    assign pop      = rd.valid & rd.ready;

    assign {rd.sof, rd.data} = mem[rd_ptr];   // head word shown directly

    always_ff @(posedge clk_50M) begin
        if (push) begin
            mem[wr_ptr] <= {wr.sof, wr.data};
        end
    end

    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sticky until cleared, a new drop wins over the clear
    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            overflow_o <= 1'b0;
        end else if (wr.valid && !wr.ready) begin
            overflow_o <= 1'b1;
        end else if (ovf_clr_i) begin
            overflow_o <= 1'b0;
        end
    end

endmodule

// ==== verilog/pixel_adjust.sv ====
`timescale 1ns/1ps

module pixel_adjust (
    input  logic                         clk_50M,
    input  logic                         sys_rst,
    pix_if.snk                           in,
    input  cam_pkg::bright_t             bright_i,
    input  logic                         gray_en_i,
    output logic                         valid_o,
    input  logic                         ready_i,
    output logic                         sof_o,
    output logic [cam_pkg::PIX888_W-1:0] rgb888_o
);

    logic [7:0]  r8;    // expanded channels
    logic [7:0]  g8;
    logic [7:0]  b8;
    logic [15:0] luma_sum;
    logic [7:0]  r_sel;
    logic [7:0]  g_sel;
    logic [7:0]  b_sel;
    logic        load;

    // channel plus signed offset, clamped to 0..255
    function automatic logic [7:0] add_clamp(input logic [7:0] ch,
                                             input cam_pkg::bright_t ofs);
        logic signed [9:0] sum;
        sum = $signed({2'b00, ch}) + ofs;
        if (sum < 0) begin
            return 8'h00;
        end else if (sum > 255) begin
            return 8'hff;
        end
        return sum[7:0];
    endfunction

    assign r8 = {in.data[15:11], in.data[15:13]};   // top bits repeated
    assign g8 = {in.data[10:5], in.data[10:9]};
    assign b8 = {in.data[4:0], in.data[4:2]};

    assign luma_sum = 16'd77 * r8 + 16'd150 * g8 + 16'd29 * b8;

    always_comb begin
        if (gray_en_i) begin
            r_sel = luma_sum[15:8];
            g_sel = luma_sum[15:8];
            b_sel = luma_sum[15:8];
        end else begin
            r_sel = r8;
            g_sel = g8;
            b_sel = b8;
        end
    end

    // output register takes a new word when empty or drained
    assign in.ready = ~valid_o | ready_i;
    assign load     = in.valid & in.ready;

    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            valid_o <= 1'b0;
            sof_o   <= 1'b0;
        end else if (in.ready) begin
            valid_o <= in.valid;
            if (in.valid) begin
                sof_o <= in.sof;
            end
        end
    end

    always_ff @(posedge clk_50M) begin
        if (load) begin
            rgb888_o <= {add_clamp(r_sel, bright_i),
                         add_clamp(g_sel, bright_i),
                         add_clamp(b_sel, bright_i)};
        end
    end

endmodule

// ==== verilog/cmd_regs.sv ====
`timescale 1ns/1ps

module cmd_regs (
    input  logic                       clk_50M,
    input  logic                       sys_rst,
    input  logic [cam_pkg::APB_AW-1:0] paddr_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  logic [cam_pkg::APB_DW-1:0] pwdata_i,
    output logic [cam_pkg::APB_DW-1:0] prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    input  logic                       overflow_i,
    output cam_pkg::bright_t           bright_o,
    output logic                       gray_en_o,
    output logic                       ovf_clr_o
);

    cam_pkg::cmd_byte_u        cmd;
    logic                      access;      // APB access phase
    logic                      addr_ok;
    logic                      cmd_wr;
    logic signed [8:0]         bright_up;   // one bit of headroom
    logic signed [8:0]         bright_dn;
    logic [cam_pkg::APB_DW-1:0] status;

    assign cmd.raw   = pwdata_i[cam_pkg::BYTE_W-1:0];
    assign access    = psel_i & penable_i;
    assign addr_ok   = (paddr_i == cam_pkg::ADDR_CMD) || (paddr_i == cam_pkg::ADDR_STATUS);
    assign cmd_wr    = access & pwrite_i & (paddr_i == cam_pkg::ADDR_CMD);

    assign pready_o  = 1'b1;   // zero wait states
    assign pslverr_o = access & ~addr_ok;

    assign status    = {6'd0, overflow_i, gray_en_o, bright_o};
    assign prdata_o  = (access && !pwrite_i && paddr_i == cam_pkg::ADDR_STATUS) ? status : '0;

    assign ovf_clr_o = cmd_wr & (cmd.fields.ctrl == cam_pkg::CMD_CLR_OVF);

    assign bright_up = $signed({bright_o[7], bright_o}) + $signed({5'd0, cmd.fields.value});
    assign bright_dn = $signed({bright_o[7], bright_o}) - $signed({5'd0, cmd.fields.value});

    always_ff @(posedge clk_50M or negedge sys_rst) begin
        if (!sys_rst) begin
            bright_o  <= '0;
            gray_en_o <= 1'b0;
        end else if (cmd_wr) begin
            case (cmd.fields.ctrl)
                cam_pkg::CMD_BRIGHT_UP: begin
                    if (bright_up > cam_pkg::BRIGHT_MAX) begin
                        bright_o <= cam_pkg::bright_t'(cam_pkg::BRIGHT_MAX);
                    end else begin
                        bright_o <= cam_pkg::bright_t'(bright_up);
                    end
                end
                cam_pkg::CMD_BRIGHT_DOWN: begin
                    if (bright_dn < -cam_pkg::BRIGHT_MAX) begin
                        bright_o <= cam_pkg::bright_t'(-cam_pkg::BRIGHT_MAX);
                    end else begin
                        bright_o <= cam_pkg::bright_t'(bright_dn);
                    end
                end
                cam_pkg::CMD_GRAY: begin
                    gray_en_o <= cmd.fields.value[0];
                end
                default: begin
                    // overflow clear goes out as a pulse, other codes ignored
                end
            endcase
        end
    end

endmodule

// ==== verilog/cam_pipe_top.sv ====
`timescale 1ns/1ps

module cam_pipe_top (
    input  logic                         clk_50M,
    input  logic                         sys_rst,
    input  logic                         cmos_href_i,
    input  logic                         cmos_vsync_i,
    input  logic [cam_pkg::BYTE_W-1:0]   cmos_data_i,
    input  logic [cam_pkg::APB_AW-1:0]   paddr_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [cam_pkg::APB_DW-1:0]   pwdata_i,
    output logic [cam_pkg::APB_DW-1:0]   prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    output logic                         pix_valid_o,
    input  logic                         pix_ready_i,
    output logic                         pix_sof_o,
    output logic [cam_pkg::PIX888_W-1:0] pix_rgb888_o
);

    cam_pkg::bright_t bright;     // brightness offset
    logic             gray_en;
    logic             overflow;   // sticky FIFO drop flag
    logic             ovf_clr;

    pix_if u_pack_if ();          // packer to FIFO
    pix_if u_adj_if ();           // FIFO to adjuster

    cmos_pixel_pack u_cmos_pixel_pack (
        .clk_50M  (clk_50M),
        .sys_rst  (sys_rst),
        .href_i   (cmos_href_i),
        .vsync_i  (cmos_vsync_i),
        .data_i   (cmos_data_i),
        .pix      (u_pack_if.src)
    );

    pixel_fifo u_pixel_fifo (
        .clk_50M    (clk_50M),
        .sys_rst    (sys_rst),
        .wr         (u_pack_if.snk),
        .rd         (u_adj_if.src),
        .ovf_clr_i  (ovf_clr),
        .overflow_o (overflow)
    );

    pixel_adjust u_pixel_adjust (
        .clk_50M   (clk_50M),
        .sys_rst   (sys_rst),
        .in        (u_adj_if.snk),
        .bright_i  (bright),
        .gray_en_i (gray_en),
        .valid_o   (pix_valid_o),
        .ready_i   (pix_ready_i),
        .sof_o     (pix_sof_o),
        .rgb888_o  (pix_rgb888_o)
    );

    cmd_regs u_cmd_regs (
        .clk_50M    (clk_50M),
        .sys_rst    (sys_rst),
        .paddr_i    (paddr_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .overflow_i (overflow),
        .bright_o   (bright),
        .gray_en_o  (gray_en),
        .ovf_clr_o  (ovf_clr)
    );

endmodule

// ==== tb/cam_pipe_assert.sv ====
`timescale 1ns/1ps

module cam_pipe_assert (
    input logic        clk_50M,
    input logic        sys_rst,
    input logic        valid_i,
    input logic        ready_i,
    input logic [24:0] payload_i,   // {sof, rgb888}
    input logic        psel_i,
    input logic        penable_i,
    input logic        pready_i,
    input logic        pslverr_i
);

    int fail_cnt = 0;

    // stalled output word stays put until taken
    hold_chk: assert property (@(posedge clk_50M) disable iff (!sys_rst)
        valid_i && !ready_i |=> valid_i && $stable(payload_i))
        else begin
            $error("output word changed while stalled");
            fail_cnt++;
        end

    ready_chk: assert property (@(posedge clk_50M) disable iff (!sys_rst) pready_i)
        else begin
            $error("pready dropped low");
            fail_cnt++;
        end

    slverr_chk: assert property (@(posedge clk_50M) disable iff (!sys_rst)
        pslverr_i |-> psel_i && penable_i)
        else begin
            $error("pslverr outside an access phase");
            fail_cnt++;
        end

endmodule

bind pixel_adjust cam_pipe_assert u_adjust_chk (
    .clk_50M   (clk_50M),
    .sys_rst   (sys_rst),
    .valid_i   (valid_o),
    .ready_i   (ready_i),
    .payload_i ({sof_o, rgb888_o}),
    .psel_i    (1'b0),
    .penable_i (1'b0),
    .pready_i  (1'b1),
    .pslverr_i (1'b0)
);

bind cmd_regs cam_pipe_assert u_apb_chk (
    .clk_50M   (clk_50M),
    .sys_rst   (sys_rst),
    .valid_i   (1'b0),
    .ready_i   (1'b1),
    .payload_i (25'd0),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o)
);

// ==== tb/cam_pipe_tb.sv ====
`timescale 1ns/1ps

module cam_pipe_tb;

    typedef enum {APB_WR, APB_RD, FRAME, STALL} step_kind_e;

    logic                         clk_50M;
    logic                         sys_rst;
    logic                         cmos_href_i;
    logic                         cmos_vsync_i;
    logic [cam_pkg::BYTE_W-1:0]   cmos_data_i;
    logic [cam_pkg::APB_AW-1:0]   paddr_i;
    logic                         psel_i;
    logic                         penable_i;
    logic                         pwrite_i;
    logic [cam_pkg::APB_DW-1:0]   pwdata_i;
    logic [cam_pkg::APB_DW-1:0]   prdata_o;
    logic                         pready_o;
    logic                         pslverr_o;
    logic                         pix_valid_o;
    logic                         pix_ready_i;
    logic                         pix_sof_o;
    logic [cam_pkg::PIX888_W-1:0] pix_rgb888_o;

    // step table held as parallel queues
    string                        name_q[$];
    step_kind_e                   kind_q[$];
    logic [cam_pkg::APB_AW-1:0]   addr_q[$];
    logic [cam_pkg::BYTE_W-1:0]   cmd_q[$];
    int                           npix_q[$];
    logic [cam_pkg::APB_DW-1:0]   stat_q[$];

    logic [cam_pkg::PIX888_W-1:0] exp_rgb_q[$];   // expected pixels in arrival order
    logic                         exp_sof_q[$];
    string                        cur_name;
    bit                           check_en = 1'b1;
    cam_pkg::bright_t             model_bright = '0;
    logic                         model_gray = 1'b0;
    int                           pix_errs = 0;
    int                           stat_errs = 0;
    int                           slv_errs = 0;
    int                           other_errs = 0;
    int                           limit_cyc = 0;

    cam_pipe_top u_cam_pipe_top (.*);

    initial begin
        clk_50M = 1'b0;
        forever #10 clk_50M = ~clk_50M;
    end

    function automatic void add_step(input string name, input step_kind_e kind,
                                     input logic [3:0] addr, input logic [7:0] cmd,
                                     input int npix, input logic [15:0] stat);
        name_q.push_back(name);
        kind_q.push_back(kind);
        addr_q.push_back(addr);
        cmd_q.push_back(cmd);
        npix_q.push_back(npix);
        stat_q.push_back(stat);
    endfunction

    function automatic void add_cmd(input string name, input logic [3:0] ctrl,
                                    input logic [3:0] value, input logic [15:0] stat);
        cam_pkg::cmd_byte_u c;
        c.fields.ctrl  = ctrl;
        c.fields.value = value;
        add_step(name, APB_WR, cam_pkg::ADDR_CMD, c.raw, 0, stat);
    endfunction

    function automatic logic addr_bad(input logic [cam_pkg::APB_AW-1:0] addr);
        return addr != cam_pkg::ADDR_CMD && addr != cam_pkg::ADDR_STATUS;
    endfunction

    // widen a channel by repeating its top bits below it
    function automatic logic [7:0] expand_channel(input logic [7:0] ch, input int bits);
        return (ch << (8 - bits)) | (ch >> (2 * bits - 8));
    endfunction

    function automatic logic [7:0] offset_clamp(input int ch, input cam_pkg::bright_t ofs);
        int v;
        v = ch + ofs;
        if (v < 0) v = 0;
        if (v > 255) v = 255;
        return 8'(v);
    endfunction

    function automatic logic [cam_pkg::PIX888_W-1:0] model_pixel(input logic [15:0] w);
        int r;
        int g;
        int b;
        int y;
        r = expand_channel(w[15:11], 5);
        g = expand_channel(w[10:5], 6);
        b = expand_channel(w[4:0], 5);
        if (model_gray) begin
            y = (77 * r + 150 * g + 29 * b) >> 8;   // luma
            r = y;
            g = y;
            b = y;
        end
        return {offset_clamp(r, model_bright), offset_clamp(g, model_bright),
                offset_clamp(b, model_bright)};
    endfunction

    task automatic check_pixel(input string name, input logic [cam_pkg::PIX888_W-1:0] exp_rgb,
                               input logic [cam_pkg::PIX888_W-1:0] act_rgb,
                               input logic exp_sof, input logic act_sof,
                               input cam_pkg::bright_t bright);
        if (act_rgb !== exp_rgb || act_sof !== exp_sof) begin
            pix_errs++;
            $display("FAIL %s: expected rgb %06h sof %0b, actual rgb %06h sof %0b, bright %0d",
                     name, exp_rgb, exp_sof, act_rgb, act_sof, bright);
        end
    endtask

    task automatic check_status(input string name, input logic [cam_pkg::APB_DW-1:0] exp_st,
                                input logic [cam_pkg::APB_DW-1:0] act_st);
        if (act_st !== exp_st) begin
            stat_errs++;
            $display("FAIL %s: status expected %04h, actual %04h", name, exp_st, act_st);
        end
    endtask

    task automatic check_err(input string name, input logic exp_err, input logic act_err);
        if (act_err !== exp_err) begin
            slv_errs++;
            $display("FAIL %s: pslverr expected %0b, actual %0b", name, exp_err, act_err);
        end
    endtask

    task automatic apb_xfer(input logic [cam_pkg::APB_AW-1:0] addr, input logic wr,
                            input logic [cam_pkg::APB_DW-1:0] wdata,
                            output logic [cam_pkg::APB_DW-1:0] rdata, output logic err);
        @(posedge clk_50M);
        psel_i    <= 1'b1;   // setup phase
        penable_i <= 1'b0;
        paddr_i   <= addr;
        pwrite_i  <= wr;
        pwdata_i  <= wdata;
        @(posedge clk_50M);
        penable_i <= 1'b1;
        @(negedge clk_50M);  // mid access phase
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_50M);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic send_frame(input int npix, input bit keep);
        logic [15:0] w;
        @(posedge clk_50M);
        cmos_vsync_i <= 1'b1;
        repeat (2) @(posedge clk_50M);
        cmos_vsync_i <= 1'b0;
        @(posedge clk_50M);
        for (int i = 0; i < npix; i++) begin
            w = 16'($urandom);
            if (keep) begin
                exp_rgb_q.push_back(model_pixel(w));
                exp_sof_q.push_back(i == 0);
            end
            @(posedge clk_50M);
            cmos_href_i <= 1'b1;
            cmos_data_i <= w[15:8];   // high byte first
            @(posedge clk_50M);
            cmos_data_i <= w[7:0];
        end
        @(posedge clk_50M);
        cmos_href_i <= 1'b0;
    endtask

    always @(posedge clk_50M) begin
        if (sys_rst && check_en && pix_valid_o && pix_ready_i) begin
            if (exp_rgb_q.size() == 0) begin
                other_errs++;
                $display("ERROR: step %s produced a pixel that was not expected", cur_name);
            end else begin
                check_pixel(cur_name, exp_rgb_q.pop_front(), pix_rgb888_o,
                            exp_sof_q.pop_front(), pix_sof_o, model_bright);
            end
        end
    end

    initial begin
        wait (limit_cyc > 0);
        repeat (limit_cyc) @(posedge clk_50M);
        $display("ERROR: run hung, tests did not finish within %0d cycles", limit_cyc);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int                         b;
        int                         budget;
        int                         assert_errs;
        logic [cam_pkg::APB_DW-1:0] rd;
        logic                       err;
        bit                         keep;
        void'($urandom(32'hea98));
        sys_rst      = 1'b0;
        cmos_href_i  = 1'b0;
        cmos_vsync_i = 1'b0;
        cmos_data_i  = '0;
        paddr_i      = '0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        pwdata_i     = '0;
        pix_ready_i  = 1'b1;

        b = 0;
        add_step("reset_status", APB_RD, cam_pkg::ADDR_STATUS, 8'h00, 0, 16'h0000);
        add_step("color_frame_a", FRAME, 4'h0, 8'h00, 20, 16'h0000);
        add_step("color_frame_b", FRAME, 4'h0, 8'h00, 9, 16'h0000);
        for (int i = 0; i < 9; i++) begin
            b = (b + 15 > cam_pkg::BRIGHT_MAX) ? cam_pkg::BRIGHT_MAX : b + 15;
            add_cmd("bright_up", cam_pkg::CMD_BRIGHT_UP, 4'd15, {8'h00, 8'(b)});
        end
        add_step("bright_max_frame", FRAME, 4'h0, 8'h00, 12, 16'h0000);
        for (int i = 0; i < 18; i++) begin
            b = (b - 15 < -cam_pkg::BRIGHT_MAX) ? -cam_pkg::BRIGHT_MAX : b - 15;
            add_cmd("bright_down", cam_pkg::CMD_BRIGHT_DOWN, 4'd15, {8'h00, 8'(b)});
        end
        add_step("bright_min_frame", FRAME, 4'h0, 8'h00, 12, 16'h0000);
        for (int i = 0; i < 8; i++) begin
            b = b + 15;
            add_cmd("bright_back", cam_pkg::CMD_BRIGHT_UP, 4'd15, {8'h00, 8'(b)});
        end
        add_cmd("gray_on", cam_pkg::CMD_GRAY, 4'd1, {8'h01, 8'(b)});
        add_step("gray_frame_dim", FRAME, 4'h0, 8'h00, 12, 16'h0000);
        b = b + 7;
        add_cmd("bright_zero", cam_pkg::CMD_BRIGHT_UP, 4'd7, {8'h01, 8'(b)});
        add_step("gray_frame", FRAME, 4'h0, 8'h00, 12, 16'h0000);
        add_cmd("gray_off", cam_pkg::CMD_GRAY, 4'd0, 16'h0000);
        add_cmd("unknown_cmd", 4'h5, 4'hf, 16'h0000);
        add_step("short_stall", STALL, 4'h0, 8'h00, 12, 16'h0000);
        add_step("long_stall", STALL, 4'h0, 8'h00, 24, 16'h0000);
        add_step("ovf_status", APB_RD, cam_pkg::ADDR_STATUS, 8'h00, 0, 16'h0200);
        add_cmd("ovf_clear", cam_pkg::CMD_CLR_OVF, 4'd0, 16'h0000);
        add_step("bad_addr_write", APB_WR, 4'h8, 8'h1f, 0, 16'h0000);   // bright up 15
        add_step("bad_addr_read", APB_RD, 4'hc, 8'h00, 0, 16'h0000);
        add_step("color_frame_end", FRAME, 4'h0, 8'h00, 10, 16'h0000);

        repeat (16) @(posedge clk_50M);
        sys_rst <= 1'b1;
        budget = 0;
        foreach (npix_q[s]) budget += npix_q[s] * 2 + 20;
        limit_cyc = budget;   // starts the watchdog

        for (int s = 0; s < name_q.size(); s++) begin
            cur_name = name_q[s];
            case (kind_q[s])
                APB_WR: begin
                    apb_xfer(addr_q[s], 1'b1, {8'h00, cmd_q[s]}, rd, err);
                    check_err(cur_name, addr_bad(addr_q[s]), err);
                    apb_xfer(cam_pkg::ADDR_STATUS, 1'b0, '0, rd, err);
                    check_err(cur_name, 1'b0, err);
                    check_status(cur_name, stat_q[s], rd);
                    model_bright = cam_pkg::bright_t'(stat_q[s][7:0]);
                    model_gray   = stat_q[s][8];
                end
                APB_RD: begin
                    apb_xfer(addr_q[s], 1'b0, '0, rd, err);
                    check_err(cur_name, addr_bad(addr_q[s]), err);
                    if (!addr_bad(addr_q[s])) check_status(cur_name, stat_q[s], rd);
                end
                default: begin
                    keep = (kind_q[s] == FRAME) || (npix_q[s] <= cam_pkg::FIFO_DEPTH);
                    check_en = keep;
                    if (kind_q[s] == STALL) begin
                        @(posedge clk_50M);
                        pix_ready_i <= 1'b0;
                    end
                    send_frame(npix_q[s], keep);
                    @(posedge clk_50M);
                    pix_ready_i <= 1'b1;
                    if (keep) begin
                        while (exp_rgb_q.size() != 0) @(posedge clk_50M);
                    end else begin
                        do @(posedge clk_50M); while (pix_valid_o);   // drained
                    end
                    check_en = 1'b1;
                end
            endcase
        end

        assert_errs = u_cam_pipe_top.u_pixel_adjust.u_adjust_chk.fail_cnt
                    + u_cam_pipe_top.u_cmd_regs.u_apb_chk.fail_cnt;
        $display("errors: pixel %0d, status %0d, pslverr %0d, other %0d, assertion %0d",
                 pix_errs, stat_errs, slv_errs, other_errs, assert_errs);
        if (pix_errs + stat_errs + slv_errs + other_errs + assert_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/cam_pkg.sv
verilog/pix_if.sv
verilog/cmos_pixel_pack.sv
verilog/pixel_fifo.sv
verilog/pixel_adjust.sv
verilog/cmd_regs.sv
verilog/cam_pipe_top.sv
tb/cam_pipe_assert.sv
tb/cam_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: cam_pipe

sources:
  - verilog/cam_pkg.sv
  - verilog/pix_if.sv
  - verilog/cmos_pixel_pack.sv
  - verilog/pixel_fifo.sv
  - verilog/pixel_adjust.sv
  - verilog/cmd_regs.sv
  - verilog/cam_pipe_top.sv
  - target: test
    files:
      - tb/cam_pipe_assert.sv
      - tb/cam_pipe_tb.sv
